// File: source/frontend_pkg.sv
// Front end package with queue sizing, opcodes, fetch entry and decoded instruction types
package frontend_pkg;

    // Instruction queue sizing, depth must stay a power of two
    localparam int i_queue_depth = 8;
    localparam int i_queue_ptr_w = $clog2(i_queue_depth);
    localparam int i_queue_cnt_w = i_queue_ptr_w + 1;

    // Fetch restarts here after reset
    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // RV32I base opcodes, low two bits included
    localparam logic [6:0] op_alu_reg  = 7'b0110011;
    localparam logic [6:0] op_alu_imm  = 7'b0010011;
    localparam logic [6:0] op_load     = 7'b0000011;
    localparam logic [6:0] op_store    = 7'b0100011;
    localparam logic [6:0] op_branch   = 7'b1100011;
    localparam logic [6:0] op_jal      = 7'b1101111;
    localparam logic [6:0] op_jalr     = 7'b1100111;
    localparam logic [6:0] op_lui      = 7'b0110111;
    localparam logic [6:0] op_auipc    = 7'b0010111;
    localparam logic [6:0] op_system   = 7'b1110011;
    localparam logic [6:0] op_misc_mem = 7'b0001111;

    // One queue slot as written by fetch
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] instr;
    } fetch_entry_t;

    typedef enum logic [3:0] {
        alu_reg,
        alu_imm,
        load,
        store,
        branch,
        jal,
        jalr,
        lui,
        auipc,
        system,
        illegal
    } instr_class_e;

    // Handed to the issue stage
    typedef struct packed {
        logic [31:0]  pc;
        logic [31:0]  next_pc;
        instr_class_e iclass;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [2:0]   funct3;
        logic         funct7_bit5;
        // Sign extended for every format
        logic [31:0]  imm;
    } decoded_instr_t;

endpackage

// File: source/fetch_unit.sv
// Fetch unit sequencing the PC and issuing single-outstanding memory reads into the queue
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     redirect,
    input  logic [31:0]                              redirect_pc,
    input  logic                                     imem_rvalid,
    input  logic [31:0]                              imem_rdata,
    input  logic [frontend_pkg::i_queue_cnt_w-1:0]   q_count,
    output logic                                     imem_req,
    output logic [31:0]                              imem_addr,
    output logic                                     q_write,
    output frontend_pkg::fetch_entry_t               q_wdata
);

    logic [31:0]                          pc;
    logic [31:0]                          req_addr;
    logic                                 live;
    logic                                 fetch_en;
    logic                                 pending;
    logic                                 slot_free;
    logic [frontend_pkg::i_queue_cnt_w:0] credit_sum;

    // A response only counts while its request is still live
    assign q_write = imem_rvalid && live;
    assign pending = live && !imem_rvalid;

    // Slots already taken or promised once this edge has passed
    assign credit_sum = {1'b0, q_count}
                      + (frontend_pkg::i_queue_cnt_w + 1)'(pending)
                      + (frontend_pkg::i_queue_cnt_w + 1)'(q_write);
    assign slot_free  = credit_sum
                      < (frontend_pkg::i_queue_cnt_w + 1)'(frontend_pkg::i_queue_depth);

    assign imem_req  = fetch_en && !redirect && (!live || imem_rvalid) && slot_free;
    assign imem_addr = pc;

    assign q_wdata = '{pc:      req_addr,
                       next_pc: req_addr + 32'd4,
                       instr:   imem_rdata};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= frontend_pkg::reset_pc;
            live     <= 1'b0;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (redirect) begin
                // Anything answering next cycle is stale and gets dropped
                pc   <= redirect_pc;
                live <= 1'b0;
            end else if (imem_req) begin
                pc   <= pc + 32'd4;
                live <= 1'b1;
            end else if (imem_rvalid) begin
                live <= 1'b0;
            end
        end
    end

    // Address of the outstanding request
    always_ff @(posedge clk) begin
        if (imem_req) begin
            req_addr <= pc;
        end
    end

    // Memory answers exactly one cycle after a request, never unprompted
    a_rvalid_after_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_rvalid |-> $past(imem_req)
    );

endmodule

// File: source/i_queue.sv
// Instruction queue holding fetch entries in a circular buffer with show-ahead head output
`timescale 1ns/1ps

module i_queue (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     flush,
    input  logic                                     read,
    input  logic                                     write,
    input  frontend_pkg::fetch_entry_t               data_in,
    output frontend_pkg::fetch_entry_t               data_out,
    output logic                                     empty,
    output logic [frontend_pkg::i_queue_cnt_w-1:0]   count
);

    frontend_pkg::fetch_entry_t mem [frontend_pkg::i_queue_depth];

    logic [frontend_pkg::i_queue_ptr_w-1:0] head;
    logic [frontend_pkg::i_queue_ptr_w-1:0] tail;
    logic                                   full;
    logic                                   do_write;
    logic                                   do_read;

    assign empty = (count == '0);
    assign full  = (count == frontend_pkg::i_queue_cnt_w'(frontend_pkg::i_queue_depth));

    assign do_write = write && !full;
    assign do_read  = read && !empty;

    // Head entry always visible, no pop needed to see it
    assign data_out = mem[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Pointers wrap on their own since depth is a power of two
            if (do_write) begin
                tail <= tail + 1'b1;
            end
            if (do_read) begin
                head <= head + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[tail] <= data_in;
        end
    end

    // Fetch credit check keeps the buffer from overflowing
    a_no_write_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        write |-> !full
    );

    // Decoder only pops what it can see
    a_no_read_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        read |-> !empty
    );

endmodule

// File: source/rv32i_decoder.sv
// RV32I decoder popping queue entries and registering class, fields and immediate
`timescale 1ns/1ps

module rv32i_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         hold,
    input  logic                         flush,
    input  logic                         q_empty,
    input  frontend_pkg::fetch_entry_t   q_rdata,
    output logic                         q_read,
    output logic                         dec_valid,
    output frontend_pkg::decoded_instr_t dec_instr
);

    logic [31:0]                instr;
    logic [6:0]                 opcode;
    frontend_pkg::instr_class_e iclass;
    logic [31:0]                imm_i;
    logic [31:0]                imm_s;
    logic [31:0]                imm_b;
    logic [31:0]                imm_u;
    logic [31:0]                imm_j;
    logic [31:0]                imm;

    assign instr  = q_rdata.instr;
    assign opcode = instr[6:0];

    // Pop the head unless the issue side stalls or a redirect is flushing
    assign q_read = !q_empty && !hold && !flush;

    // Immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            frontend_pkg::op_alu_reg:  iclass = frontend_pkg::alu_reg;
            frontend_pkg::op_alu_imm:  iclass = frontend_pkg::alu_imm;
            frontend_pkg::op_load:     iclass = frontend_pkg::load;
            frontend_pkg::op_store:    iclass = frontend_pkg::store;
            frontend_pkg::op_branch:   iclass = frontend_pkg::branch;
            frontend_pkg::op_jal:      iclass = frontend_pkg::jal;
            frontend_pkg::op_jalr:     iclass = frontend_pkg::jalr;
            frontend_pkg::op_lui:      iclass = frontend_pkg::lui;
            frontend_pkg::op_auipc:    iclass = frontend_pkg::auipc;
            frontend_pkg::op_system:   iclass = frontend_pkg::system;
            // Fence has no class of its own and is treated like system
            frontend_pkg::op_misc_mem: iclass = frontend_pkg::system;
            default:                   iclass = frontend_pkg::illegal;
        endcase
    end

    always_comb begin
        case (iclass)
            frontend_pkg::alu_imm,
            frontend_pkg::load,
            frontend_pkg::jalr,
            frontend_pkg::system:  imm = imm_i;
            frontend_pkg::store:   imm = imm_s;
            frontend_pkg::branch:  imm = imm_b;
            frontend_pkg::lui,
            frontend_pkg::auipc:   imm = imm_u;
            frontend_pkg::jal:     imm = imm_j;
            default:               imm = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= q_read;
        end
    end

    // Decoded payload is only loaded on a pop
    always_ff @(posedge clk) begin
        if (q_read) begin
            dec_instr.pc          <= q_rdata.pc;
            dec_instr.next_pc     <= q_rdata.next_pc;
            dec_instr.iclass      <= iclass;
            dec_instr.rd          <= instr[11:7];
            dec_instr.rs1         <= instr[19:15];
            dec_instr.rs2         <= instr[24:20];
            dec_instr.funct3      <= instr[14:12];
            dec_instr.funct7_bit5 <= instr[30];
            dec_instr.imm         <= imm;
        end
    end

    // A strobe always carries an entry that fetch actually wrote into the queue
    a_valid_from_entry : assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> !$isunknown(dec_instr)
    );

endmodule

// File: source/frontend_top.sv
// Instruction front end top connecting fetch, instruction queue and decoder
`timescale 1ns/1ps

module frontend_top (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         imem_req,
    output logic [31:0]                  imem_addr,
    input  logic                         imem_rvalid,
    input  logic [31:0]                  imem_rdata,
    input  logic                         redirect,
    input  logic [31:0]                  redirect_pc,
    input  logic                         hold,
    output logic                         dec_valid,
    output frontend_pkg::decoded_instr_t dec_instr
);

    logic                                   q_write;
    frontend_pkg::fetch_entry_t             q_wdata;
    logic [frontend_pkg::i_queue_cnt_w-1:0] q_count;
    frontend_pkg::fetch_entry_t             q_rdata;
    logic                                   q_empty;
    logic                                   q_read;

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_rvalid (imem_rvalid),
        .imem_rdata  (imem_rdata),
        .q_count     (q_count),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .q_write     (q_write),
        .q_wdata     (q_wdata)
    );

    // Redirect empties the queue at the same edge
    i_queue u_i_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (redirect),
        .read     (q_read),
        .write    (q_write),
        .data_in  (q_wdata),
        .data_out (q_rdata),
        .empty    (q_empty),
        .count    (q_count)
    );

    rv32i_decoder u_rv32i_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (hold),
        .flush     (redirect),
        .q_empty   (q_empty),
        .q_rdata   (q_rdata),
        .q_read    (q_read),
        .dec_valid (dec_valid),
        .dec_instr (dec_instr)
    );

endmodule

// File: bench/frontend_tb.sv
// Testbench for the instruction front end with memory model, hold patterns and decode checks
`timescale 1ns/1ps

module frontend_tb;

    localparam int num_rows        = 24;
    localparam int mem_words       = 64;
    localparam int watchdog_cycles = num_rows * 3 * 20 + 200;

    // One program word with the decode it must produce
    typedef struct packed {
        logic [31:0]                word;
        frontend_pkg::instr_class_e iclass;
        logic [4:0]                 rd;
        logic [4:0]                 rs1;
        logic [4:0]                 rs2;
        logic [31:0]                imm;
    } row_t;

    logic                         clk;
    logic                         rst_n;
    logic                         imem_req;
    logic [31:0]                  imem_addr;
    logic                         imem_rvalid;
    logic [31:0]                  imem_rdata;
    logic                         redirect;
    logic [31:0]                  redirect_pc;
    logic                         hold;
    logic                         dec_valid;
    frontend_pkg::decoded_instr_t dec_instr;

    row_t        rows [num_rows];
    logic [31:0] imem [mem_words];
    string       current_test = "reset";
    logic [31:0] exp_pc       = frontend_pkg::reset_pc;
    bit          seen_req     = 0;
    bit          after_redirect = 0;
    int          req_count    = 0;
    int          dec_count    = 0;
    int          outstanding  = 0;
    int          illegal_seen = 0;
    int          decode_errors = 0;
    int          pc_errors    = 0;
    int          class_errors = 0;
    int          count_errors = 0;
    int          other_errors = 0;

    frontend_top u_frontend_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rvalid (imem_rvalid),
        .imem_rdata  (imem_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .hold        (hold),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr)
    );

    always #2 clk = ~clk;

    // Memory answers every request one cycle later
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_rvalid <= 1'b0;
        end else begin
            imem_rvalid <= imem_req;
            imem_rdata  <= imem[imem_addr[7:2]];
        end
    end

    task automatic check_decoded(input string name, input frontend_pkg::decoded_instr_t exp,
                                 input frontend_pkg::decoded_instr_t act);
        if (act !== exp) begin
            decode_errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            pc_errors++;
            $display("Mismatch %s: expected pc %h actual pc %h", name, exp, act);
        end
    endtask

    task automatic check_class(input string name, input frontend_pkg::instr_class_e exp,
                               input frontend_pkg::instr_class_e act);
        if (act !== exp) begin
            class_errors++;
            $display("Mismatch %s: expected class %s actual class %s", name, exp.name(),
                     act.name());
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            count_errors++;
            $display("Mismatch %s: expected count %0d actual count %0d", name, exp, act);
        end
    endtask

    // Reference decode from the table with funct fields at their standard positions
    function automatic frontend_pkg::decoded_instr_t expect_decode(input logic [31:0] pc);
        row_t                         r;
        frontend_pkg::decoded_instr_t d;
        r             = rows[((pc >> 2) % mem_words) % num_rows];
        d.pc          = pc;
        d.next_pc     = pc + 32'd4;
        d.iclass      = r.iclass;
        d.rd          = r.rd;
        d.rs1         = r.rs1;
        d.rs2         = r.rs2;
        d.funct3      = r.word[14:12];
        d.funct7_bit5 = r.word[30];
        d.imm         = r.imm;
        return d;
    endfunction

    // Monitor for requests, decodes and the outstanding bound
    always @(posedge clk) begin
        if (rst_n) begin
            if (imem_req) begin
                if (!seen_req) begin
                    check_pc("first request", frontend_pkg::reset_pc, imem_addr);
                end
                seen_req = 1;
                req_count++;
                outstanding++;
            end
            if (dec_valid) begin
                check_pc(after_redirect ? "redirect target" : current_test, exp_pc,
                         dec_instr.pc);
                check_class(current_test, expect_decode(exp_pc).iclass, dec_instr.iclass);
                check_decoded(current_test, expect_decode(exp_pc), dec_instr);
                if (expect_decode(exp_pc).iclass == frontend_pkg::illegal) begin
                    illegal_seen++;
                end
                after_redirect = 0;
                exp_pc         = exp_pc + 32'd4;
                dec_count++;
                outstanding--;
            end
            if (outstanding > frontend_pkg::i_queue_depth) begin
                count_errors++;
                $display("Mismatch %s: expected at most %0d outstanding actual %0d",
                         current_test, frontend_pkg::i_queue_depth, outstanding);
            end
            if (redirect) begin
                // Everything fetched so far is either decoded or flushed
                exp_pc         = redirect_pc;
                after_redirect = 1;
                outstanding    = 0;
            end
        end
    end

    // Runs until n more strobes arrive with hold low or random
    task automatic run_decodes(input int n, input bit random_hold);
        int target;
        @(negedge clk);
        target = dec_count + n;
        while (dec_count < target) begin
            @(posedge clk);
            hold <= random_hold && ($urandom % 2 == 1);
            @(negedge clk);
        end
    endtask

    task automatic do_redirect(input logic [31:0] target);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        hold        <= ($urandom % 2 == 1);
        @(posedge clk);
        redirect    <= 1'b0;
        hold        <= ($urandom % 2 == 1);
    endtask

    // Hold high long enough to fill the queue and then release
    task automatic fill_queue();
        int occ_start;
        int r0;
        int d0;
        int r_mid;
        int r_end;
        @(posedge clk);
        hold <= 1'b1;
        @(negedge clk);
        occ_start = req_count - dec_count;
        r0        = req_count;
        d0        = dec_count;
        repeat (20) @(negedge clk);
        r_mid = req_count;
        repeat (10) @(negedge clk);
        check_count("full queue stalls fetch", r_mid, req_count);
        check_count("full queue requests", frontend_pkg::i_queue_depth - occ_start
                    + (dec_count - d0), req_count - r0);
        r_end = req_count;
        @(posedge clk);
        hold <= 1'b0;
        repeat (20) @(negedge clk);
        if (req_count == r_end) begin
            other_errors++;
            $display("Fetch did not resume within 20 cycles after hold fell");
        end
    endtask

    initial begin
        void'($urandom(48));
        clk         = 1'b0;
        rst_n       = 1'b0;
        imem_rvalid = 1'b0;
        imem_rdata  = 32'd0;
        redirect    = 1'b0;
        redirect_pc = 32'd0;
        hold        = 1'b0;

        rows[0]  = '{32'h003100B3, frontend_pkg::alu_reg, 1, 2, 3, 32'h0000_0000};
        rows[1]  = '{32'h407302B3, frontend_pkg::alu_reg, 5, 6, 7, 32'h0000_0000};
        rows[2]  = '{32'hFFF00513, frontend_pkg::alu_imm, 10, 0, 31, 32'hFFFF_FFFF};
        rows[3]  = '{32'h06450593, frontend_pkg::alu_imm, 11, 10, 4, 32'h0000_0064};
        rows[4]  = '{32'h4035D613, frontend_pkg::alu_imm, 12, 11, 3, 32'h0000_0403};
        rows[5]  = '{32'hFFC12683, frontend_pkg::load, 13, 2, 28, 32'hFFFF_FFFC};
        rows[6]  = '{32'h0080C703, frontend_pkg::load, 14, 1, 8, 32'h0000_0008};
        rows[7]  = '{32'h0051A623, frontend_pkg::store, 12, 3, 5, 32'h0000_000C};
        rows[8]  = '{32'hFE621F23, frontend_pkg::store, 30, 4, 6, 32'hFFFF_FFFE};
        rows[9]  = '{32'h00208863, frontend_pkg::branch, 16, 1, 2, 32'h0000_0010};
        rows[10] = '{32'hFE419CE3, frontend_pkg::branch, 25, 3, 4, 32'hFFFF_FFF8};
        rows[11] = '{32'h001000EF, frontend_pkg::jal, 1, 0, 1, 32'h0000_0800};
        rows[12] = '{32'hFFDFF06F, frontend_pkg::jal, 0, 31, 29, 32'hFFFF_FFFC};
        rows[13] = '{32'h00008067, frontend_pkg::jalr, 0, 1, 0, 32'h0000_0000};
        rows[14] = '{32'hFF0302E7, frontend_pkg::jalr, 5, 6, 16, 32'hFFFF_FFF0};
        rows[15] = '{32'h123453B7, frontend_pkg::lui, 7, 8, 3, 32'h1234_5000};
        rows[16] = '{32'hFFFFF437, frontend_pkg::lui, 8, 31, 31, 32'hFFFF_F000};
        rows[17] = '{32'h00001497, frontend_pkg::auipc, 9, 0, 0, 32'h0000_1000};
        rows[18] = '{32'h80000517, frontend_pkg::auipc, 10, 0, 0, 32'h8000_0000};
        rows[19] = '{32'h00000073, frontend_pkg::system, 0, 0, 0, 32'h0000_0000};
        rows[20] = '{32'h300110F3, frontend_pkg::system, 1, 2, 0, 32'h0000_0300};
        rows[21] = '{32'h00100073, frontend_pkg::system, 0, 0, 1, 32'h0000_0001};
        // Opcodes outside the base set
        rows[22] = '{32'hFFFFFFFF, frontend_pkg::illegal, 31, 31, 31, 32'h0000_0000};
        rows[23] = '{32'h12345657, frontend_pkg::illegal, 12, 8, 3, 32'h0000_0000};
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = rows[i % num_rows].word;
        end

        repeat (2) begin
            @(negedge clk);
            if (imem_req !== 1'b0 || dec_valid !== 1'b0) begin
                other_errors++;
                $display("imem_req or dec_valid was high during reset");
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (imem_req !== 1'b0 || dec_valid !== 1'b0) begin
            other_errors++;
            $display("imem_req or dec_valid was high right after reset");
        end

        current_test = "decode";
        run_decodes(30, 1'b0);
        current_test = "back-pressure";
        run_decodes(48, 1'b1);
        current_test = "full queue";
        fill_queue();
        current_test = "redirect";
        run_decodes(5, 1'b1);
        do_redirect(32'h0000_0050);
        run_decodes(30, 1'b1);
        do_redirect(32'h0000_0024);
        run_decodes(30, 1'b1);

        if (illegal_seen == 0) begin
            other_errors++;
            $display("No illegal instruction was decoded during the run");
        end
        $display("Errors: decode %0d, pc %0d, class %0d, count %0d, other %0d",
                 decode_errors, pc_errors, class_errors, count_errors, other_errors);
        if (decode_errors + pc_errors + class_errors + count_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not reach its end", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sources.f
source/frontend_pkg.sv
source/fetch_unit.sv
source/i_queue.sv
source/rv32i_decoder.sv
source/frontend_top.sv
bench/frontend_tb.sv
